//--- bench/aux_audio_stimulus.txt
# M <word offset> <16-bit SDRAM word>   values in hex
# D <left 24-bit audio> <right 24-bit audio>   values in hex
M 0000 1234
M 0001 abcd
M 0002 0f1e
M 0003 7788
M 0004 c3a5
M 0005 5aa5
M 0006 0102
M 0007 fe01
M 0008 4321
M 0009 89ab
M 000a 3c3c
M 000b e00f
M 000c 1357
M 000d 2468
M 000e 9bdf
M 000f 0ace
D 000000 800000
D 7fffff 000000
D 123456 fedcba
D 400000 c00000
D 0000ff 7fff00

//--- src.f
+incdir+common
common/aux_audio_pkg.sv
aux_stream/aux_stream_fetch.sv
aux_stream/aux_sample_pacer.sv
audio_dac/sigma_delta_dac.sv
design/aux_audio_top.sv
bench/aux_audio_tb.sv

//--- Bender.yml
package:
  name: aux_audio

sources:
  - include_dirs:
      - common
    files:
      - common/aux_audio_pkg.sv
      - aux_stream/aux_stream_fetch.sv
      - aux_stream/aux_sample_pacer.sv
      - audio_dac/sigma_delta_dac.sv
      - design/aux_audio_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/aux_audio_tb.sv

//--- bench/aux_audio_tb.sv
// Aux audio path testbench
// SDRAM burst model, aux stream order checks and DAC density checks

`timescale 1ns/1ps
`default_nettype none

`include "aux_audio_config.svh"

module aux_audio_tb import aux_audio_pkg::*; ();

  localparam int    NUM_WORDS = 1 << `AUD_WORD_ADDR_W;
  localparam int    MARGIN    = 8;      // Watchdog slack per record
  localparam int    DAC_WIN   = 4096;   // Density window in cycles
  localparam string STIM_FILE = "bench/aux_audio_stimulus.txt";

  logic          clk_114 = 1'b0;
  logic          reset;
  logic          aud_ena;
  aud_chip_t     amiga_left;
  aud_chip_t     amiga_right;
  logic          ram_ack;
  logic          ram_fill;
  aud_sample_t   ram_data;
  logic          ram_req;
  aud_ram_addr_t ram_addr;
  aud_sample_t   aux_left;
  aud_sample_t   aux_right;
  logic          audio_l;
  logic          audio_r;

  aud_sample_t   mem [NUM_WORDS];
  aud_chip_t     dac_l_q [$];
  aud_chip_t     dac_r_q [$];
  int            n_records = 0;
  int            errors = 0;
  int            words_seen = 0;
  logic          stim_ok = 1'b0;
  logic          hold_ack = 1'b0;   // Withholds ram_ack while set
  aud_word_ofs_t stream_idx = '0;   // Next word due on the aux outputs
  aud_word_ofs_t next_ofs = '0;     // Next burst offset due on ram_addr
  aud_sample_t   prev_left = '0;
  aud_sample_t   prev_right = '0;

  aux_audio_top UUT (.*);

  initial begin
    forever #10 clk_114 = ~clk_114;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic aud_sample_t swap_bytes(input aud_sample_t w);
    return {w[7:0], w[15:8]};
  endfunction

  // Offset binary value scaled down to 16 bits
  function automatic int dac_level(input aud_chip_t v);
    return (int'(v) + (1 << (`AUD_CHIP_W - 1))) >> (`AUD_CHIP_W - `AUD_SAMPLE_W);
  endfunction

  // Pulse count may sit one off the ideal density
  task automatic check_density(input string name, input int expected, input int count);
    if (count < expected - 1 || count > expected + 1) begin
      check_value(name, expected, count);
    end
  endtask

  // Odd multiplier keeps every word in the window distinct
  function automatic aud_sample_t fill_word(input logic [31:0] ofs);
    return aud_sample_t'(ofs * 32'h9e37 + 32'h5a5a);
  endfunction

  task automatic load_stimulus();
    int               fd;
    int               code;
    logic [8*80-1:0]  text_line;
    logic [31:0]      a;
    logic [31:0]      b;
    for (int i = 0; i < NUM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(text_line, fd);
        if (code > 0 && $sscanf(text_line, "M %h %h", a, b) == 2) begin
          mem[a[15:0]] = b[15:0];
          n_records++;
        end else if (code > 0 && $sscanf(text_line, "D %h %h", a, b) == 2) begin
          dac_l_q.push_back(a[23:0]);
          dac_r_q.push_back(b[23:0]);
          n_records++;
        end
      end
      $fclose(fd);
      stim_ok = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // SDRAM model
  ////////////////////////////////////////
  task automatic serve_burst();
    aud_ram_addr_t req_addr;
    int            gap;
    logic          aborted;
    req_addr = ram_addr;
    aborted  = 1'b0;
    check_value("ram_addr prefix", `AUD_WINDOW_PREFIX, req_addr[22:16]);
    check_value("ram_addr offset", next_ofs, req_addr[15:0]);
    gap = $urandom_range(6, 0);
    while (!aborted && (gap > 0 || hold_ack)) begin
      @(negedge clk_114);
      if (!aud_ena) begin
        aborted = 1'b1;
      end else begin
        check_value("ram_req", 1, ram_req);       // Held until ack
        check_value("ram_addr", req_addr, ram_addr);
        if (gap > 0) begin
          gap--;
        end
      end
    end
    if (!aborted) begin
      ram_ack = 1'b1;
      @(negedge clk_114);
      ram_ack = 1'b0;
      for (int i = 0; i < `AUD_BURST_LEN && !aborted; i++) begin
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk_114);
        if (!aud_ena) begin
          aborted = 1'b1;   // Flushed burst gets no more words
        end else begin
          ram_fill = 1'b1;
          ram_data = mem[aud_word_ofs_t'(req_addr[15:0] + i)];
          @(negedge clk_114);
          ram_fill = 1'b0;
        end
      end
      if (!aborted) begin
        next_ofs = next_ofs + aud_word_ofs_t'(`AUD_BURST_LEN);
      end
    end
  endtask

  initial begin : mem_model
    void'($urandom(11461));
    ram_ack  = 1'b0;
    ram_fill = 1'b0;
    ram_data = '0;
    forever begin
      @(negedge clk_114);
      if (!aud_ena) begin
        next_ofs = '0;
      end else if (ram_req) begin
        serve_burst();
      end
    end
  end

  // Each aux update must be the next word of the stream
  always @(negedge clk_114) begin
    if (!reset && aux_left !== prev_left) begin
      check_value("aux_left", swap_bytes(mem[stream_idx]), aux_left);
      stream_idx++;
      words_seen++;
    end
    if (!reset && aux_right !== prev_right) begin
      check_value("aux_right", swap_bytes(mem[stream_idx]), aux_right);
      stream_idx++;
      words_seen++;
    end
    prev_left  = aux_left;
    prev_right = aux_right;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  task automatic wait_words(input int count);
    int target;
    target = words_seen + count;
    wait (words_seen >= target);
    @(negedge clk_114);
  endtask

  task automatic check_reset_state();
    check_value("ram_req", 0, ram_req);
    check_value("aux_left", 0, aux_left);
    check_value("aux_right", 0, aux_right);
    check_value("audio_l", 0, audio_l);
    check_value("audio_r", 0, audio_r);
    repeat (50) begin   // Disabled stream never requests
      @(negedge clk_114);
      check_value("ram_req", 0, ram_req);
    end
  endtask

  task automatic run_dac_case(input aud_chip_t left, input aud_chip_t right);
    int ones_l;
    int ones_r;
    int exp_l;
    int exp_r;
    amiga_left  = left;
    amiga_right = right;
    exp_l  = dac_level(left) * DAC_WIN / 65536;
    exp_r  = dac_level(right) * DAC_WIN / 65536;
    ones_l = 0;
    ones_r = 0;
    repeat (2) @(negedge clk_114);
    repeat (DAC_WIN) begin
      ones_l += audio_l;
      ones_r += audio_r;
      @(negedge clk_114);
    end
    check_density("audio_l ones", exp_l, ones_l);
    check_density("audio_r ones", exp_r, ones_r);
  endtask

  initial begin : main_seq
    int mark;
    reset       = 1'b1;
    aud_ena     = 1'b0;
    amiga_left  = '0;
    amiga_right = '0;
    load_stimulus();
    repeat (4) @(negedge clk_114);
    reset = 1'b0;
    if (stim_ok) begin
      check_reset_state();
      aud_ena = 1'b1;
      wait_words(16);
      // Restart from the window base
      aud_ena    = 1'b0;
      stream_idx = '0;
      repeat (20) @(negedge clk_114);
      aud_ena = 1'b1;
      wait_words(8);
      // Controller stall drains the FIFO and freezes the outputs
      hold_ack = 1'b1;
      repeat (20 * `AUD_TICK_PERIOD) @(negedge clk_114);
      mark = words_seen;
      repeat (10 * `AUD_TICK_PERIOD) @(negedge clk_114);
      check_value("aux words during stall", mark, words_seen);
      hold_ack = 1'b0;
      wait_words(8);
      foreach (dac_l_q[i]) begin
        run_dac_case(dac_l_q[i], dac_r_q[i]);
      end
    end
    $display("Run complete with %0d errors over %0d aux words", errors, words_seen);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    wait (stim_ok);
    repeat (n_records * `AUD_TICK_PERIOD * MARGIN) @(posedge clk_114);
    $display("Timeout after %0d sample periods without finishing", n_records * MARGIN);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/aux_audio_top.sv
// Aux audio path top level
// SDRAM sample stream, stereo pacing and sigma-delta DAC pins

`timescale 1ns/1ps
`default_nettype none

`include "aux_audio_config.svh"

module aux_audio_top import aux_audio_pkg::*; (
  input  logic          clk_114,
  input  logic          reset,
  input  logic          aud_ena,
  input  aud_chip_t     amiga_left,
  input  aud_chip_t     amiga_right,
  input  logic          ram_ack,
  input  logic          ram_fill,
  input  aud_sample_t   ram_data,
  output logic          ram_req,
  output aud_ram_addr_t ram_addr,
  output aud_sample_t   aux_left,    // Paced aux samples
  output aud_sample_t   aux_right,
  output logic          audio_l,     // DAC pins
  output logic          audio_r
);

  // Fetcher to pacer
  logic        fifo_empty;
  logic        fifo_rd;
  aud_sample_t fifo_q;

  ////////////////////////////////////////
  // Aux sample stream
  ////////////////////////////////////////
  aux_stream_fetch u_fetch (
    .clk_114    (clk_114),
    .reset      (reset),
    .aud_ena    (aud_ena),
    .ram_req    (ram_req),
    .ram_addr   (ram_addr),
    .ram_ack    (ram_ack),
    .ram_fill   (ram_fill),
    .ram_data   (ram_data),
    .fifo_rd    (fifo_rd),
    .fifo_q     (fifo_q),
    .fifo_empty (fifo_empty)
  );

  aux_sample_pacer u_pacer (
    .clk_114    (clk_114),
    .reset      (reset),
    .fifo_empty (fifo_empty),
    .fifo_q     (fifo_q),
    .fifo_rd    (fifo_rd),
    .aux_left   (aux_left),
    .aux_right  (aux_right)
  );

  ////////////////////////////////////////
  // Chipset audio DAC
  ////////////////////////////////////////
  sigma_delta_dac u_dac (
    .clk_114     (clk_114),
    .reset       (reset),
    .amiga_left  (amiga_left),
    .amiga_right (amiga_right),
    .audio_l     (audio_l),
    .audio_r     (audio_r)
  );

endmodule

`default_nettype wire

//--- audio_dac/sigma_delta_dac.sv
// Two-channel sigma-delta audio DAC
// Chipset audio to unsigned 16 bit, then a first-order modulator per pin

`timescale 1ns/1ps
`default_nettype none

`include "aux_audio_config.svh"

module sigma_delta_dac import aux_audio_pkg::*; (
  input  logic      clk_114,
  input  logic      reset,
  input  aud_chip_t amiga_left,
  input  aud_chip_t amiga_right,
  output logic      audio_l,
  output logic      audio_r
);

  localparam int NUM_CH = 2;   // Left is channel 0

  aud_chip_t         chip_in [NUM_CH];
  aud_sample_t       dac_cvt [NUM_CH];
  aud_sample_t       dac_in  [NUM_CH];
  aud_sample_t       dac_acc [NUM_CH];
  logic [NUM_CH-1:0] dac_bit;

  assign chip_in[0] = amiga_left;
  assign chip_in[1] = amiga_right;

  ////////////////////////////////////////
  // Signed to unsigned
  ////////////////////////////////////////
  // Sign flip of the top bits gives offset binary
  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      dac_cvt[ch] = {~chip_in[ch][`AUD_CHIP_W-1],
                     chip_in[ch][`AUD_CHIP_W-2 -: `AUD_SAMPLE_W-1]};
    end
  end

  ////////////////////////////////////////
  // Modulator
  ////////////////////////////////////////
  // Carry out of the accumulator is the pulse density output
  always_ff @(posedge clk_114) begin
    if (reset) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        dac_in[ch]  <= '0;
        dac_acc[ch] <= '0;
        dac_bit[ch] <= 1'b0;
      end
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        dac_in[ch] <= dac_cvt[ch];                        // Input stage
        {dac_bit[ch], dac_acc[ch]} <= {1'b0, dac_acc[ch]} + {1'b0, dac_in[ch]};
      end
    end
  end

  assign audio_l = dac_bit[0];
  assign audio_r = dac_bit[1];

endmodule

`default_nettype wire

//--- aux_stream/aux_sample_pacer.sv
// Aux sample pacer
// Reads a left/right word pair per sample period and byte-swaps them out

`timescale 1ns/1ps
`default_nettype none

`include "aux_audio_config.svh"

module aux_sample_pacer import aux_audio_pkg::*; (
  input  logic        clk_114,
  input  logic        reset,
  input  logic        fifo_empty,
  input  aud_sample_t fifo_q,
  output logic        fifo_rd,
  output aud_sample_t aux_left,
  output aud_sample_t aux_right
);

  localparam int TICK_W = $clog2(`AUD_TICK_PERIOD);
  localparam int HALF_W = `AUD_SAMPLE_W / 2;

  logic [TICK_W-1:0] tick_ctr;
  logic              left_slot;
  logic              right_slot;   // Left word was taken last cycle
  logic              left_rd;
  logic              right_rd;
  aud_sample_t       swapped;

  // Wrap cycle doubles as the left slot
  assign left_slot = tick_ctr == TICK_W'(`AUD_TICK_PERIOD - 1);
  assign left_rd   = left_slot && !fifo_empty;
  assign right_rd  = right_slot && !fifo_empty;  // Underrun keeps old right
  assign fifo_rd   = left_rd || right_rd;

  // SDRAM words arrive big-endian
  assign swapped = {fifo_q[HALF_W-1:0], fifo_q[`AUD_SAMPLE_W-1:HALF_W]};

  ////////////////////////////////////////
  // Period counter and slots
  ////////////////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset) begin
      tick_ctr   <= '0;
      right_slot <= 1'b0;
    end else begin
      right_slot <= left_rd;  // Empty left slot skips the whole pair
      if (left_slot) begin
        tick_ctr <= '0;
      end else begin
        tick_ctr <= tick_ctr + 1'b1;
      end
    end
  end

  // Output registers
  always_ff @(posedge clk_114) begin
    if (reset) begin
      aux_left  <= '0;
      aux_right <= '0;
    end else begin
      if (left_rd) begin
        aux_left <= swapped;
      end
      if (right_rd) begin
        aux_right <= swapped;
      end
    end
  end

  // At most a left and a right read back to back
  a_rd_burst: assert property (@(posedge clk_114) disable iff (reset)
    fifo_rd ##1 fifo_rd |=> !fifo_rd);

endmodule

`default_nettype wire

//--- aux_stream/aux_stream_fetch.sv
// Aux stream fetcher
// Pulls fixed-window SDRAM bursts into a show-ahead sample FIFO

`timescale 1ns/1ps
`default_nettype none

`include "aux_audio_config.svh"

module aux_stream_fetch import aux_audio_pkg::*; (
  input  logic          clk_114,
  input  logic          reset,
  input  logic          aud_ena,      // Low flushes the stream
  output logic          ram_req,
  output aud_ram_addr_t ram_addr,
  input  logic          ram_ack,
  input  logic          ram_fill,
  input  aud_sample_t   ram_data,
  input  logic          fifo_rd,
  output aud_sample_t   fifo_q,       // Head word when not empty
  output logic          fifo_empty
);

  localparam int PTR_W  = $clog2(`AUD_FIFO_DEPTH);
  localparam int CNT_W  = $clog2(`AUD_FIFO_DEPTH + 1);
  localparam int BEAT_W = $clog2(`AUD_BURST_LEN);

  fetch_state_e      state;
  aud_word_ofs_t     word_ofs;
  logic [BEAT_W-1:0] beat_cnt;
  aud_sample_t       fifo_mem [`AUD_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fill_cnt;
  logic              room_for_burst;
  logic              last_beat;
  logic              fill_take;
  logic              rd_take;

  assign room_for_burst = fill_cnt <= CNT_W'(`AUD_FIFO_DEPTH - `AUD_BURST_LEN);
  assign last_beat = beat_cnt == BEAT_W'(`AUD_BURST_LEN - 1);
  assign fill_take = aud_ena && (state == FETCH_FILL) && ram_fill;  // Stale fills dropped
  assign rd_take   = fifo_rd && !fifo_empty;

  assign ram_req  = (state == FETCH_REQ);
  assign ram_addr = {`AUD_WINDOW_PREFIX, word_ofs};

  ////////////////////////////////////////
  // Burst FSM
  ////////////////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset || !aud_ena) begin
      state    <= FETCH_IDLE;
      word_ofs <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (room_for_burst) begin
            state <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          if (ram_ack) begin
            state <= FETCH_FILL;
          end
        end
        FETCH_FILL: begin
          if (ram_fill) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state    <= FETCH_IDLE;
              beat_cnt <= '0;
              // Wraps inside the window on its own
              word_ofs <= word_ofs + aud_word_ofs_t'(`AUD_BURST_LEN);
            end
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Sample FIFO
  ////////////////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset || !aud_ena) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (fill_take) begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      end
      if (rd_take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill_cnt <= fill_cnt + CNT_W'(fill_take) - CNT_W'(rd_take);
    end
  end

  always_ff @(posedge clk_114) begin
    if (fill_take) begin
      fifo_mem[wr_ptr] <= ram_data;
    end
  end

  assign fifo_q     = fifo_mem[rd_ptr];
  assign fifo_empty = (fill_cnt == '0);

  // Controller sees a steady request until it acks
  a_req_hold: assert property (@(posedge clk_114) disable iff (reset)
    ram_req && !ram_ack && aud_ena |=> ram_req && $stable(ram_addr));

  // Fill strobes only belong to an acked burst
  a_fill_in_burst: assert property (@(posedge clk_114) disable iff (reset)
    aud_ena && ram_fill |-> state == FETCH_FILL);

  // Pacer must honour the empty flag
  a_no_read_empty: assert property (@(posedge clk_114) disable iff (reset)
    fifo_rd |-> !fifo_empty);

endmodule

`default_nettype wire

//--- common/aux_audio_pkg.sv
// Aux audio shared types
// Sample, chipset audio and address types plus the fetch FSM states

`default_nettype none

`include "aux_audio_config.svh"

package aux_audio_pkg;

  // Raw word as stored in SDRAM
  typedef logic [`AUD_SAMPLE_W-1:0] aud_sample_t;

  // Chipset mixer output in two's complement
  typedef logic signed [`AUD_CHIP_W-1:0] aud_chip_t;

  typedef logic [`AUD_RAM_ADDR_W-1:0] aud_ram_addr_t;   // Word address
  typedef logic [`AUD_WORD_ADDR_W-1:0] aud_word_ofs_t;  // Offset in window

  ////////////////////////////////////////
  // Fetcher FSM
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    FETCH_IDLE,   // Waiting for FIFO room
    FETCH_REQ,    // Request held until ack
    FETCH_FILL    // Collecting the burst words
  } fetch_state_e;

endpackage

`default_nettype wire

//--- common/aux_audio_config.svh
// Aux audio path configuration
// Widths, SDRAM window placement, burst and FIFO sizing, sample pacing

`ifndef AUX_AUDIO_CONFIG_SVH
`define AUX_AUDIO_CONFIG_SVH

////////////////////////////////////////
// Data widths
////////////////////////////////////////
`define AUD_SAMPLE_W      16         // One aux sample word
`define AUD_CHIP_W        24         // Chipset audio per channel
`define AUD_WORD_ADDR_W   16         // Word offset inside the window
`define AUD_RAM_ADDR_W    23         // Full SDRAM word address

////////////////////////////////////////
// SDRAM window and fetch sizing
////////////////////////////////////////
// Upper address bits place the window at 0x6f0000
`define AUD_WINDOW_PREFIX 7'b1101111
`define AUD_BURST_LEN     4          // Words per fill burst
`define AUD_FIFO_DEPTH    16         // Power of two

////////////////////////////////////////
// Pacing
////////////////////////////////////////
// clk_114 cycles per stereo pair
`define AUD_TICK_PERIOD   2572

`endif
